// File: testbench/icache_input.txt
# columns: op, lookup address, expected hit, expected refill address, expected 64-bit word
# op 0 lookup with random beat gaps, op 1 lookup with back-to-back beats, op 2 reset
1 00001000 0 00001000 0000000000000000
1 00001000 1 00000000 EFFB1004EFFF1000
1 00001008 1 00000000 EFF3100CEFF71008
1 00001010 1 00000000 EFEB1014EFEF1010
1 00001018 1 00000000 EFE3101CEFE71018
0 00002000 0 00002000 0000000000000000
0 00002008 1 00000000 DFF3200CDFF72008
0 00001018 0 00001000 0000000000000000
0 00001018 1 00000000 EFE3101CEFE71018
0 00001000 1 00000000 EFFB1004EFFF1000
0 00003020 0 00003020 0000000000000000
0 00004040 0 00004040 0000000000000000
0 00005060 0 00005060 0000000000000000
0 00001008 1 00000000 EFF3100CEFF71008
0 00003028 1 00000000 CFD3302CCFD73028
0 00004040 1 00000000 BFBB4044BFBF4040
0 00005078 1 00000000 AF83507CAF875078
0 80001010 0 80001000 0000000000000000
0 80001010 1 00000000 EFEB1014EFEF1010
2 00000000 0 00000000 0000000000000000
0 00003028 0 00003020 0000000000000000
0 00003028 1 00000000 CFD3302CCFD73028

// File: verilog.f
common/cache_pkg.sv
refill/align_r.sv
refill/line_ram.sv
refill/refill_fsm.sv
logic/tag_array.sv
logic/icache_top.sv
testbench/icache_checker.sv
testbench/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
# build the cache testbench with verilator and run it from the project root.
# the result is taken from the simulation log.
verilator --binary --assert --top-module tb_icache -f verilog.f -o tb_icache > build.log 2>&1 \
   || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_icache > sim.log 2>&1 \
   || { echo "simulation exited with an error, see sim.log"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

// File: testbench/tb_icache.sv
/*
 testbench top for the read cache.
 clock, reset, memory model with random beat gaps,
 lookups read from the stimulus file, checker instance.
 */
module tb_icache;
   import cache_pkg::*;

   localparam int TIMEOUT_CYCLES = 200;

   logic      i_clk;
   logic      i_rst_n;
   logic      i_lkp_valid;
   addr_t     i_lkp_addr;
   logic      o_lkp_rsp;
   logic      o_lkp_hit;
   ram_data_t o_lkp_data;
   logic      o_mem_req;
   addr_t     o_mem_addr;
   logic      i_mem_rvalid;
   logic      i_mem_rlast;
   bus_data_t i_mem_rdata;
   logic      o_busy;
   logic      o_refill_done;

   // expectations for the lookup in flight.
   logic      exp_hit;
   addr_t     exp_mem_addr;
   ram_data_t exp_data;
   int        test_id;

   int        test_count;
   int        fail_count;
   int        err_count;
   int        lookups;
   bit        timed_out;
   bit        back_to_back;

   icache_top i_icache_top
   (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_lkp_valid   (i_lkp_valid),
      .i_lkp_addr    (i_lkp_addr),
      .o_lkp_rsp     (o_lkp_rsp),
      .o_lkp_hit     (o_lkp_hit),
      .o_lkp_data    (o_lkp_data),
      .o_mem_req     (o_mem_req),
      .o_mem_addr    (o_mem_addr),
      .i_mem_rvalid  (i_mem_rvalid),
      .i_mem_rlast   (i_mem_rlast),
      .i_mem_rdata   (i_mem_rdata),
      .o_busy        (o_busy),
      .o_refill_done (o_refill_done)
   );

   icache_checker u_checker
   (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_lkp_valid    (i_lkp_valid),
      .i_lkp_addr     (i_lkp_addr),
      .i_lkp_rsp      (o_lkp_rsp),
      .i_lkp_hit      (o_lkp_hit),
      .i_lkp_data     (o_lkp_data),
      .i_mem_req      (o_mem_req),
      .i_mem_addr     (o_mem_addr),
      .i_busy         (o_busy),
      .i_refill_done  (o_refill_done),
      .i_exp_hit      (exp_hit),
      .i_exp_mem_addr (exp_mem_addr),
      .i_exp_data     (exp_data),
      .i_test_id      (test_id),
      .o_test_count   (test_count),
      .o_fail_count   (fail_count),
      .o_err_count    (err_count)
   );

   initial
   begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   // memory content: inverted low half of the address above the low half.
   function automatic bus_data_t mem_word(input addr_t a);
      return {~a[15:0], a[15:0]};
   endfunction

   // one line of beats, with or without idle cycles between them.
   task automatic send_line(input addr_t base);
      int gap;
      for (int b = 0; b < BEATS_PER_LINE; b++)
      begin
         gap = back_to_back ? 0 : int'($urandom % 32'd4);
         repeat (gap)
         begin
            @(posedge i_clk);
            i_mem_rvalid <= 1'b0;
            i_mem_rlast <= 1'b0;
         end
         @(posedge i_clk);
         i_mem_rvalid <= 1'b1;
         i_mem_rdata <= mem_word(base + addr_t'(b * 4));
         i_mem_rlast <= (b == BEATS_PER_LINE - 1);
      end
      @(posedge i_clk);
      i_mem_rvalid <= 1'b0;
      i_mem_rlast <= 1'b0;
   endtask

   // memory model answers every request seen in a response cycle.
   // the beat gaps are drawn here, so the seed is set here.
   initial
   begin
      void'($urandom(38426));
      i_mem_rvalid <= 1'b0;
      i_mem_rlast <= 1'b0;
      i_mem_rdata <= '0;
      forever
      begin
         @(negedge i_clk);
         if (o_mem_req)
         begin
            send_line(o_mem_addr);
         end
      end
   end

   // waits for the response, or for the refill end when refill is set.
   task automatic wait_for(input bit refill);
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge i_clk);
         cycles++;
      end
      while (!(refill ? o_refill_done : o_lkp_rsp) && cycles < TIMEOUT_CYCLES);
      if (!(refill ? o_refill_done : o_lkp_rsp))
      begin
         $display("timeout: no %s within %0d cycles",
                  refill ? "refill done pulse" : "lookup response", TIMEOUT_CYCLES);
         timed_out = 1'b1;
      end
   endtask

   task automatic run_lookup(input addr_t addr, input logic hit, input addr_t maddr,
                             input ram_data_t data);
      @(posedge i_clk);
      i_lkp_valid <= 1'b1;
      i_lkp_addr <= addr;
      exp_hit <= hit;
      exp_mem_addr <= maddr;
      exp_data <= data;
      test_id <= test_id + 1;
      lookups++;
      @(posedge i_clk);
      i_lkp_valid <= 1'b0;
      wait_for(1'b0);
      // a miss keeps the cache busy until the line is in.
      if (!timed_out && !o_lkp_hit)
      begin
         wait_for(1'b1);
      end
   endtask

   task automatic apply_reset();
      @(posedge i_clk);
      i_rst_n <= 1'b0;
      repeat (5) @(posedge i_clk);
      i_rst_n <= 1'b1;
   endtask

   initial
   begin : stimulus
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_op;
      logic [31:0] f_addr;
      logic [31:0] f_hit;
      logic [31:0] f_maddr;
      logic [63:0] f_data;
      bit          file_ok;
      i_rst_n <= 1'b0;
      i_lkp_valid <= 1'b0;
      i_lkp_addr <= '0;
      exp_hit <= 1'b0;
      exp_mem_addr <= '0;
      exp_data <= '0;
      test_id <= 0;
      lookups = 0;
      timed_out = 1'b0;
      back_to_back = 1'b0;
      apply_reset();
      fd = $fopen("testbench/icache_input.txt", "r");
      file_ok = (fd != 0);
      if (!file_ok)
      begin
         $display("could not open testbench/icache_input.txt");
      end
      while (file_ok && !timed_out && !$feof(fd))
      begin
         n = $fgets(line, fd);
         // skip blank and comment lines.
         if (n > 1 && line.getc(0) != "#")
         begin
            n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_hit, f_maddr, f_data);
            if (n != 5)
            begin
               $display("malformed stimulus line: %s", line);
               file_ok = 1'b0;
            end
            else if (f_op == 32'd2)
            begin
               apply_reset();
            end
            else
            begin
               back_to_back = (f_op == 32'd1);
               run_lookup(f_addr, f_hit[0], f_maddr, f_data);
            end
         end
      end
      if (fd != 0)
      begin
         $fclose(fd);
      end
      repeat (3) @(posedge i_clk);
      $display("lookups %0d checked %0d failed %0d other errors %0d",
               lookups, test_count, fail_count, err_count);
      if (file_ok && !timed_out && lookups > 0 && test_count == lookups &&
          fail_count == 0 && err_count == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: testbench/icache_checker.sv
/*
 checker for the read cache.
 response timing, hit flag, data and refill request checks,
 status checks during reset and at refill end, result counts.
 */
module icache_checker
(
   input                         i_clk,
   input                         i_rst_n,
   input                         i_lkp_valid,
   input  cache_pkg::addr_t      i_lkp_addr,
   input                         i_lkp_rsp,
   input                         i_lkp_hit,
   input  cache_pkg::ram_data_t  i_lkp_data,
   input                         i_mem_req,
   input  cache_pkg::addr_t      i_mem_addr,
   input                         i_busy,
   input                         i_refill_done,
   input                         i_exp_hit,
   input  cache_pkg::addr_t      i_exp_mem_addr,
   input  cache_pkg::ram_data_t  i_exp_data,
   input  int                    i_test_id,
   output int                    o_test_count,
   output int                    o_fail_count,
   output int                    o_err_count
);
   import cache_pkg::*;

   // lookup seen on the previous falling edge.
   logic  lkp_sent_q;
   addr_t lkp_addr_q;

   initial
   begin
      o_test_count = 0;
      o_fail_count = 0;
      o_err_count = 0;
      lkp_sent_q = 1'b0;
      lkp_addr_q = '0;
   end

   task automatic check_response();
      bit bad;
      bad = 1'b0;
      if (i_lkp_hit !== i_exp_hit)
      begin
         $display("ERR o_lkp_hit exp %h got %h", i_exp_hit, i_lkp_hit);
         bad = 1'b1;
      end
      if (i_exp_hit)
      begin
         if (i_lkp_data !== i_exp_data)
         begin
            $display("ERR o_lkp_data exp %h got %h", i_exp_data, i_lkp_data);
            bad = 1'b1;
         end
         if (i_mem_req !== 1'b0)
         begin
            $display("a hit started a memory request");
            bad = 1'b1;
         end
      end
      else
      begin
         // miss: request, line address and busy all in the response cycle.
         if (i_mem_req !== 1'b1)
         begin
            $display("no memory request in the miss response cycle");
            bad = 1'b1;
         end
         else if (i_mem_addr !== i_exp_mem_addr)
         begin
            $display("ERR o_mem_addr exp %h got %h", i_exp_mem_addr, i_mem_addr);
            bad = 1'b1;
         end
         if (i_busy !== 1'b1)
         begin
            $display("o_busy did not rise with the memory request");
            bad = 1'b1;
         end
      end
      o_test_count = o_test_count + 1;
      if (bad)
      begin
         o_fail_count = o_fail_count + 1;
      end
      $display("test %0d lookup %h %s %s", i_test_id, lkp_addr_q,
               i_exp_hit ? "hit" : "miss", bad ? "failed" : "ok");
   endtask

   // outputs are sampled away from the rising edge.
   always @(negedge i_clk)
   begin
      if (!i_rst_n)
      begin
         if (i_lkp_rsp !== 1'b0 || i_mem_req !== 1'b0 || i_busy !== 1'b0 ||
             i_refill_done !== 1'b0)
         begin
            $display("status outputs not low during reset");
            o_err_count = o_err_count + 1;
         end
         lkp_sent_q = 1'b0;
      end
      else
      begin
         if (i_lkp_rsp !== lkp_sent_q)
         begin
            $display("lookup response did not come exactly one cycle after the lookup");
            o_err_count = o_err_count + 1;
         end
         if (i_lkp_rsp === 1'b1)
         begin
            check_response();
         end
         if (i_refill_done === 1'b1 && i_busy !== 1'b0)
         begin
            $display("o_busy still high when the refill done pulse came");
            o_err_count = o_err_count + 1;
         end
         lkp_sent_q = i_lkp_valid;
         lkp_addr_q = i_lkp_addr;
      end
   end

endmodule

// File: logic/icache_top.sv
/*
 read cache top level.
 tag array, refill fsm, bus to ram aligner and line ram.
 */
module icache_top
(
   input                         i_clk,
   input                         i_rst_n,
   // cpu lookup side.
   input                         i_lkp_valid,
   input  cache_pkg::addr_t      i_lkp_addr,
   output logic                  o_lkp_rsp,
   output logic                  o_lkp_hit,
   output cache_pkg::ram_data_t  o_lkp_data,
   // memory read side.
   output logic                  o_mem_req,
   output cache_pkg::addr_t      o_mem_addr,
   input                         i_mem_rvalid,
   input                         i_mem_rlast,
   input  cache_pkg::bus_data_t  i_mem_rdata,
   // status.
   output logic                  o_busy,
   output logic                  o_refill_done
);
   import cache_pkg::*;

   logic      miss_start;
   addr_t     miss_addr;
   logic      tag_we;
   index_t    tag_idx;
   tag_t      tag;
   logic      ram_we;
   ram_addr_t ram_waddr;
   ram_mask_t ram_wmsk;
   ram_data_t ram_din;

   // lookup compare and miss detect.
   tag_array u_tag_array
   (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_lkp_valid   (i_lkp_valid),
      .i_lkp_addr    (i_lkp_addr),
      .i_busy        (o_busy),
      .i_tag_we      (tag_we),
      .i_tag_idx     (tag_idx),
      .i_tag         (tag),
      .o_lkp_rsp     (o_lkp_rsp),
      .o_lkp_hit     (o_lkp_hit),
      .o_miss_start  (miss_start),
      .o_miss_addr   (miss_addr)
   );

   // line fill sequencing.
   refill_fsm u_refill_fsm
   (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_miss_start  (miss_start),
      .i_miss_addr   (miss_addr),
      .i_mem_rvalid  (i_mem_rvalid),
      .i_mem_rlast   (i_mem_rlast),
      .o_mem_req     (o_mem_req),
      .o_mem_addr    (o_mem_addr),
      .o_busy        (o_busy),
      .o_ram_we      (ram_we),
      .o_ram_addr    (ram_waddr),
      .o_tag_we      (tag_we),
      .o_tag_idx     (tag_idx),
      .o_tag         (tag),
      .o_refill_done (o_refill_done)
   );

   // each 32-bit beat lands in one half of a 64-bit ram word.
   align_r
   #(
      .AXI_P_DW_BYTES     (AXI_P_DW_BYTES),
      .PAYLOAD_P_DW_BYTES (PAYLOAD_P_DW_BYTES),
      .RAM_AW             (RAM_AW)
   )
   u_align_r
   (
      .i_axi_RDATA   (i_mem_rdata),
      .i_ram_we      (ram_we),
      .i_ram_addr    (ram_waddr),
      .o_ram_wmsk    (ram_wmsk),
      .o_ram_din     (ram_din)
   );

   // read side indexed directly by the lookup address.
   line_ram u_line_ram
   (
      .i_clk         (i_clk),
      .i_ram_we      (ram_we),
      .i_ram_wmsk    (ram_wmsk),
      .i_ram_waddr   (ram_waddr),
      .i_ram_din     (ram_din),
      .i_ram_raddr   (i_lkp_addr[RAM_AW-1:0]),
      .o_ram_dout    (o_lkp_data)
   );

endmodule

// File: logic/tag_array.sv
/*
 tag and valid storage for each line.
 tag compare at the lookup index and registered response.
 miss start pulse with the line-aligned address.
 */
module tag_array
(
   input                         i_clk,
   input                         i_rst_n,
   input                         i_lkp_valid,
   input  cache_pkg::addr_t      i_lkp_addr,
   input                         i_busy,
   input                         i_tag_we,
   input  cache_pkg::index_t     i_tag_idx,
   input  cache_pkg::tag_t       i_tag,
   output logic                  o_lkp_rsp,
   output logic                  o_lkp_hit,
   output logic                  o_miss_start,
   output cache_pkg::addr_t      o_miss_addr
);
   import cache_pkg::*;

   tag_t                   tag_mem [1<<SET_P_NUM];
   logic [(1<<SET_P_NUM)-1:0] valid_q;

   index_t lkp_idx;
   tag_t   lkp_tag;
   logic   hit;

   // address split: tag, line index, offset.
   assign lkp_idx = i_lkp_addr[LINE_P_BYTES +: SET_P_NUM];
   assign lkp_tag = i_lkp_addr[ADDR_W-1:RAM_AW];
   assign hit = valid_q[lkp_idx] && (tag_mem[lkp_idx] == lkp_tag);

   // refill makes its line valid on the last beat.
   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         valid_q <= '0;
         o_lkp_rsp <= 1'b0;
         o_lkp_hit <= 1'b0;
         o_miss_start <= 1'b0;
      end
      else
      begin
         if (i_tag_we)
         begin
            valid_q[i_tag_idx] <= 1'b1;
         end
         o_lkp_rsp <= i_lkp_valid;
         o_lkp_hit <= i_lkp_valid && hit;
         o_miss_start <= i_lkp_valid && !hit;
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (i_tag_we)
      begin
         tag_mem[i_tag_idx] <= i_tag;
      end
      // refill always fetches from the start of the line.
      if (i_lkp_valid)
      begin
         o_miss_addr <= {i_lkp_addr[ADDR_W-1:LINE_P_BYTES], {LINE_P_BYTES{1'b0}}};
      end
   end

   // cpu must hold off lookups during a refill.
   a_no_lookup_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_lkp_valid && i_busy));

endmodule

// File: refill/refill_fsm.sv
/*
 refill control for one outstanding line fill.
 issues the line request, counts bus beats, drives the ram
 write address and strobe, and writes the tag on the last beat.
 */
module refill_fsm
(
   input                         i_clk,
   input                         i_rst_n,
   input                         i_miss_start,
   input  cache_pkg::addr_t      i_miss_addr,
   input                         i_mem_rvalid,
   input                         i_mem_rlast,
   output logic                  o_mem_req,
   output cache_pkg::addr_t      o_mem_addr,
   output logic                  o_busy,
   output logic                  o_ram_we,
   output cache_pkg::ram_addr_t  o_ram_addr,
   output logic                  o_tag_we,
   output cache_pkg::index_t     o_tag_idx,
   output cache_pkg::tag_t       o_tag,
   output logic                  o_refill_done
);
   import cache_pkg::*;

   typedef enum logic [1:0]
   {
      IDLE,
      REQ,
      RECV
   } refill_state_t;

   refill_state_t state_q;
   refill_state_t state_c;
   beat_cnt_t     beat_cnt_q;
   index_t        line_idx_q;
   tag_t          line_tag_q;

   // the miss pulse is already registered, so the request cycle is
   // taken straight from it rather than from the state register.
   always_comb
   begin
      state_c = state_q;
      if ((state_q == IDLE) && i_miss_start)
      begin
         state_c = REQ;
      end
   end

   // request goes out in the lookup response cycle.
   assign o_mem_req = (state_c == REQ);
   assign o_mem_addr = i_miss_addr;
   assign o_busy = (state_c != IDLE);

   // every beat in RECV is written, there is no back-pressure.
   assign o_ram_we = (state_q == RECV) && i_mem_rvalid;
   // word offset inside the line is the beat number.
   assign o_ram_addr = {line_idx_q, beat_cnt_q, {AXI_P_DW_BYTES{1'b0}}};

   // tag goes in with the last data beat.
   assign o_tag_we = o_ram_we && i_mem_rlast;
   assign o_tag_idx = line_idx_q;
   assign o_tag = line_tag_q;

   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         state_q <= IDLE;
         beat_cnt_q <= '0;
         o_refill_done <= 1'b0;
      end
      else
      begin
         o_refill_done <= 1'b0;
         case (state_c)
            REQ:
            begin
               state_q <= RECV;
               beat_cnt_q <= '0;
            end
            RECV:
            begin
               if (i_mem_rvalid)
               begin
                  beat_cnt_q <= beat_cnt_q + 1'b1;
                  if (i_mem_rlast)
                  begin
                     state_q <= IDLE;
                     o_refill_done <= 1'b1;
                  end
               end
            end
            default:
            begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // line being filled, captured with the request.
   always_ff @(posedge i_clk)
   begin
      if (state_c == REQ)
      begin
         line_idx_q <= i_miss_addr[LINE_P_BYTES +: SET_P_NUM];
         line_tag_q <= i_miss_addr[ADDR_W-1:RAM_AW];
      end
   end

   // the last strobe marks the eighth beat and no other.
   a_rlast_on_final_beat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_ram_we |-> (i_mem_rlast == (beat_cnt_q == beat_cnt_t'(BEATS_PER_LINE - 1))));

   // memory only answers after a request has been issued.
   a_no_beat_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_mem_rvalid |-> (state_q != IDLE));

endmodule

// File: refill/line_ram.sv
/*
 line data ram, one ram word per entry.
 byte-masked write port and registered read port.
 */
module line_ram
(
   input                         i_clk,
   input                         i_ram_we,
   input  cache_pkg::ram_mask_t  i_ram_wmsk,
   input  cache_pkg::ram_addr_t  i_ram_waddr,
   input  cache_pkg::ram_data_t  i_ram_din,
   input  cache_pkg::ram_addr_t  i_ram_raddr,
   output cache_pkg::ram_data_t  o_ram_dout
);
   import cache_pkg::*;

   // 4 lines of 4 words each.
   localparam int WORD_AW = RAM_AW - PAYLOAD_P_DW_BYTES;
   localparam int BYTES = 1 << PAYLOAD_P_DW_BYTES;

   ram_data_t mem [1<<WORD_AW];

   logic [WORD_AW-1:0] waddr_w;
   logic [WORD_AW-1:0] raddr_w;

   // drop the byte offset inside the ram word.
   assign waddr_w = i_ram_waddr[RAM_AW-1:PAYLOAD_P_DW_BYTES];
   assign raddr_w = i_ram_raddr[RAM_AW-1:PAYLOAD_P_DW_BYTES];

   // each byte lane only written where its mask bit is set.
   always_ff @(posedge i_clk)
   begin
      if (i_ram_we)
      begin
         for (int b = 0; b < BYTES; b++)
         begin
            if (i_ram_wmsk[b])
            begin
               mem[waddr_w][b*8 +: 8] <= i_ram_din[b*8 +: 8];
            end
         end
      end
   end

   // read data lines up with the lookup response.
   always_ff @(posedge i_clk)
   begin
      o_ram_dout <= mem[raddr_w];
   end

endmodule

// File: refill/align_r.sv
/*
 width adapter from bus read data to ram write data.
 equal widths, wider bus and wider ram word cases,
 with the byte write mask built from the ram address.
 */
module align_r
#(
   parameter int AXI_P_DW_BYTES = cache_pkg::AXI_P_DW_BYTES,
   parameter int PAYLOAD_P_DW_BYTES = cache_pkg::PAYLOAD_P_DW_BYTES,
   parameter int RAM_AW = cache_pkg::RAM_AW
)
(
   input  logic [(1<<AXI_P_DW_BYTES)*8-1:0]      i_axi_RDATA,
   input  logic                                  i_ram_we,
   input  logic [RAM_AW-1:0]                     i_ram_addr,
   output logic [(1<<PAYLOAD_P_DW_BYTES)-1:0]    o_ram_wmsk,
   output logic [(1<<PAYLOAD_P_DW_BYTES)*8-1:0]  o_ram_din
);
   localparam int AXI_BYTES = 1 << AXI_P_DW_BYTES;
   localparam int PAYLOAD_BYTES = 1 << PAYLOAD_P_DW_BYTES;

   genvar w;

   generate
      if (PAYLOAD_P_DW_BYTES == AXI_P_DW_BYTES)
      begin : g_same
         // one bus word is one ram word.
         assign o_ram_din = i_axi_RDATA;
         assign o_ram_wmsk = {PAYLOAD_BYTES{i_ram_we}};
      end
      else if (PAYLOAD_P_DW_BYTES < AXI_P_DW_BYTES)
      begin : g_wide_bus
         localparam int SEL_W = AXI_P_DW_BYTES - PAYLOAD_P_DW_BYTES;
         localparam int WIN_DW = PAYLOAD_BYTES * 8;

         logic [WIN_DW-1:0] win [1<<SEL_W];

         // cut the bus word into ram-sized windows.
         for (w = 0; w < (1 << SEL_W); w++)
         begin : g_win
            assign win[w] = i_axi_RDATA[w*WIN_DW +: WIN_DW];
         end

         // address bits above the ram word pick the window.
         assign o_ram_din = win[i_ram_addr[PAYLOAD_P_DW_BYTES +: SEL_W]];
         assign o_ram_wmsk = {PAYLOAD_BYTES{i_ram_we}};
      end
      else
      begin : g_wide_ram
         localparam int SEL_W = PAYLOAD_P_DW_BYTES - AXI_P_DW_BYTES;

         // bus word copied into every slot of the ram word.
         for (w = 0; w < (1 << SEL_W); w++)
         begin : g_slot
            assign o_ram_din[w*AXI_BYTES*8 +: AXI_BYTES*8] = i_axi_RDATA;
            // only the slot named by the address takes the write.
            assign o_ram_wmsk[w*AXI_BYTES +: AXI_BYTES] =
               {AXI_BYTES{i_ram_we && (i_ram_addr[AXI_P_DW_BYTES +: SEL_W] == w)}};
         end
      end
   endgenerate

endmodule

// File: common/cache_pkg.sv
/*
 cache geometry for the direct-mapped read cache.
 bus and ram word widths, line size and line count.
 vector types for addresses, data, masks, tags and beat counts.
 */
package cache_pkg;

   // byte address width seen by the cpu.
   localparam int ADDR_W = 32;

   // log2 of the bus word and ram word in bytes.
   localparam int AXI_P_DW_BYTES = 2;
   localparam int PAYLOAD_P_DW_BYTES = 3;

   // log2 of the line size in bytes and of the line count.
   localparam int LINE_P_BYTES = 5;
   localparam int SET_P_NUM = 2;

   // ram byte address is the line index above the line offset.
   localparam int RAM_AW = SET_P_NUM + LINE_P_BYTES;

   // bus beats needed to fill one line.
   localparam int BEATS_PER_LINE = 1 << (LINE_P_BYTES - AXI_P_DW_BYTES);

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [(1<<AXI_P_DW_BYTES)*8-1:0] bus_data_t;
   typedef logic [(1<<PAYLOAD_P_DW_BYTES)*8-1:0] ram_data_t;
   typedef logic [(1<<PAYLOAD_P_DW_BYTES)-1:0] ram_mask_t;
   typedef logic [RAM_AW-1:0] ram_addr_t;

   // tag is everything above the line index.
   typedef logic [ADDR_W-RAM_AW-1:0] tag_t;
   typedef logic [SET_P_NUM-1:0] index_t;

   // one count per bus word in a line.
   typedef logic [LINE_P_BYTES-AXI_P_DW_BYTES-1:0] beat_cnt_t;

endpackage
